// File: design/zx_bus_pkg.sv
// ==========================================================================
// ZX CPU bus package
// CPU bus bundle, joystick types and I/O port decode constants
// ==========================================================================

`default_nettype none

package zx_bus_pkg;

	// Strobes already decoded from the active-low Z80 pins
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  dout;
		logic        mem_rd;
		logic        mem_wr;
		logic        io_rd;
		logic        io_wr;
		logic        m1;
	} cpu_bus_t;

	// Bit order matches the usual 6-bit pad word
	typedef struct packed {
		logic fire2;
		logic fire1;
		logic up;
		logic down;
		logic left;
		logic right;
	} joy_t;

	typedef enum logic [2:0] {
		JOY_KEMPSTON   = 3'd0,
		JOY_SINCLAIR1  = 3'd1,
		JOY_SINCLAIR2  = 3'd2,
		JOY_SINCLAIR12 = 3'd3,
		JOY_CURSOR     = 3'd4
	} joy_mode_t;

	localparam logic [15:0] PORT_7FFD     = 16'h7FFD;
	localparam logic [15:0] PORT_1FFD     = 16'h1FFD;
	localparam logic [15:0] PORT_EFF7     = 16'hEFF7;
	localparam logic [15:0] PORT_DFFD     = 16'hDFFD;
	localparam logic [7:0]  PORT_KEMPSTON = 8'h1F;

	// Floating bus
	localparam logic [7:0]  IDLE_BYTE     = 8'hFF;

endpackage

`default_nettype wire

// File: design/zx_mem_pkg.sv
// ==========================================================================
// ZX memory package
// Memory models, paging register state and external RAM request
// ==========================================================================

`default_nettype none

package zx_mem_pkg;

	localparam int RAM_ADDR_W = 25;
	localparam int RAM_BANK_W = 6;

	// ROM pages live above the RAM banks
	localparam logic [2:0] ROM_BASE_HI = 3'b101;

	// Same order as the machine menu entries
	typedef enum logic [2:0] {
		MEM_128K   = 3'd0,
		MEM_P1024  = 3'd1,
		MEM_PF1024 = 3'd2,
		MEM_48K    = 3'd3,
		MEM_PLUS3  = 3'd4
	} mem_model_t;

	typedef struct packed {
		logic [7:0] reg_7ffd;
		logic [7:0] reg_1ffd;
		logic [7:0] reg_eff7;
		logic [2:0] page_ext;
		logic       zx48;
		logic       p1024;
		logic       pf1024;
		logic       plus3;
	} page_state_t;

	typedef struct packed {
		logic [RAM_ADDR_W-1:0] addr;
		logic [7:0]            din;
		logic                  rd;
		logic                  we;
	} ram_req_t;

endpackage

`default_nettype wire

// File: design/zx_paging.sv
// ==========================================================================
// ZX paging registers
// Holds 7FFD, 1FFD, EFF7 and the extended bank bits for all memory
// models, and selects the ROM page
// ==========================================================================

`timescale 1ns/1ps
`default_nettype none

module zx_paging (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  zx_bus_pkg::cpu_bus_t    bus,
	input  zx_mem_pkg::mem_model_t  mem_model,
	output zx_mem_pkg::page_state_t pages,
	output logic [3:0]              rom_page
);

	import zx_bus_pkg::*;
	import zx_mem_pkg::*;

	page_state_t pg;
	logic        io_wr_d;
	logic        wr_edge;
	logic        page_lock;
	logic        sel_7ffd;
	logic        sel_1ffd;
	logic        sel_eff7;
	logic        sel_dffd;

	// One write per io_wr assertion
	assign wr_edge = bus.io_wr && !io_wr_d;

	// 48K never pages; P1024 honours the lock only with EFF7 bit 2
	assign page_lock = pg.zx48 || (pg.reg_7ffd[5] && (!pg.p1024 || pg.reg_eff7[2]));

	// ======================================================================
	// Partial port decode
	// ======================================================================
	assign sel_7ffd = (bus.addr[15] == PORT_7FFD[15]) &&
			(bus.addr[1] == PORT_7FFD[1]) &&
			(bus.addr[14] || !pg.plus3) && !page_lock;

	assign sel_1ffd = (bus.addr[15:12] == PORT_1FFD[15:12]) &&
			(bus.addr[1] == PORT_1FFD[1]) && pg.plus3 && !page_lock;

	assign sel_eff7 = (bus.addr[15:12] == PORT_EFF7[15:12]) &&
			(bus.addr[3] == PORT_EFF7[3]);

	// Profi decodes its extension port fully
	assign sel_dffd = (bus.addr == PORT_DFFD);

	always_ff @(posedge clk_sys) begin
		io_wr_d <= bus.io_wr;

		if (reset) begin
			pg <= '0;
			// Model flags only change across reset
			pg.zx48   <= (mem_model == MEM_48K);
			pg.p1024  <= (mem_model == MEM_P1024);
			pg.pf1024 <= (mem_model == MEM_PF1024);
			pg.plus3  <= (mem_model == MEM_PLUS3);
		end else if (wr_edge) begin
			if (sel_7ffd) begin
				pg.reg_7ffd <= bus.dout;
				// Pentagon upper bank bits, unless EFF7 forces 128K mode
				if (pg.p1024 && !pg.reg_eff7[2]) begin
					pg.page_ext <= {bus.dout[5], bus.dout[7:6]};
				end
			end else if (sel_1ffd) begin
				pg.reg_1ffd <= bus.dout;
			end

			if (pg.pf1024 && sel_dffd) begin
				pg.page_ext <= bus.dout[2:0];
			end

			if (pg.p1024 && sel_eff7) begin
				pg.reg_eff7 <= bus.dout;
			end
		end
	end

	// ======================================================================
	// ROM page select
	// ======================================================================
	always_comb begin
		if (pg.plus3) begin
			// Four ROMs picked by 1FFD bit 2 and 7FFD bit 4
			rom_page = {2'b10, pg.reg_1ffd[2], pg.reg_7ffd[4]};
		end else begin
			rom_page = {pg.zx48, 2'b11, pg.zx48 | pg.reg_7ffd[4]};
		end
	end

	assign pages = pg;

endmodule

`default_nettype wire

// File: design/zx_ram_map.sv
// ==========================================================================
// ZX RAM mapper
// Turns a CPU memory access into a request for the external RAM,
// with ROM write protection and the +3 all-RAM modes
// ==========================================================================

`timescale 1ns/1ps
`default_nettype none

module zx_ram_map (
	input  zx_bus_pkg::cpu_bus_t    bus,
	input  zx_mem_pkg::page_state_t pages,
	input  logic [3:0]              rom_page,
	output zx_mem_pkg::ram_req_t    ram
);

	import zx_mem_pkg::*;

	// Bank field is one bit wider than a RAM bank to cover ROM pages
	logic [RAM_BANK_W:0] bank_sel;
	logic                special;
	logic                set_hi;
	logic                set_b1;

	assign special = pages.reg_1ffd[0];
	assign set_hi  = |pages.reg_1ffd[2:1];
	assign set_b1  = &pages.reg_1ffd[2:1];

	always_comb begin
		if (special) begin
			// +3 sets: 0-1-2-3, 4-5-6-7, 4-5-6-3, 4-7-6-3
			case (bus.addr[15:14])
				2'd0:    bank_sel = {4'b0000, set_hi, 2'b00};
				2'd1:    bank_sel = {4'b0000, set_hi, set_b1, 1'b1};
				2'd2:    bank_sel = {4'b0000, set_hi, 2'b10};
				default: bank_sel = {4'b0000, ~pages.reg_1ffd[2] & pages.reg_1ffd[1], 2'b11};
			endcase
		end else begin
			case (bus.addr[15:14])
				2'd0:    bank_sel = {ROM_BASE_HI, rom_page};
				2'd1:    bank_sel = 7'd5;
				2'd2:    bank_sel = 7'd2;
				default: bank_sel = {1'b0, pages.page_ext, pages.reg_7ffd[2:0]};
			endcase
		end
	end

	always_comb begin
		ram.addr = {{(RAM_ADDR_W - RAM_BANK_W - 15){1'b0}}, bank_sel, bus.addr[13:0]};
		ram.din  = bus.dout;
		ram.rd   = bus.mem_rd;
		// Slot 0 is ROM except in the all-RAM modes
		ram.we   = bus.mem_wr && (special || bus.addr[15] || bus.addr[14]);
	end

endmodule

`default_nettype wire

// File: design/zx_joystick.sv
// ==========================================================================
// ZX joystick decode
// Kempston port data and keyboard-mapped Sinclair and Cursor sticks
// ==========================================================================

`timescale 1ns/1ps
`default_nettype none

module zx_joystick (
	input  logic                  clk_sys,
	input  zx_bus_pkg::cpu_bus_t  bus,
	input  zx_bus_pkg::joy_mode_t joy_mode,
	input  zx_bus_pkg::joy_t      joy0,
	input  zx_bus_pkg::joy_t      joy1,
	input  logic [4:0]            key_data,
	output logic [4:0]            kbd_dout,
	output logic [7:0]            kemp_dout
);

	import zx_bus_pkg::*;

	// Keys 6-0 half row, bit 0 is key 0
	function automatic logic [4:0] sinclair1_keys(input joy_t j);
		return {j.left, j.right, j.down, j.up, j.fire1};
	endfunction

	// Keys 1-5 half row, bit 0 is key 1
	function automatic logic [4:0] sinclair2_keys(input joy_t j);
		return {j.fire1, j.up, j.down, j.right, j.left};
	endfunction

	joy_t       joy_any;
	logic [4:0] row_60;
	logic [4:0] row_15;
	logic [4:0] joy_kbd;
	logic       cursor;

	assign joy_any = joy0 | joy1;
	assign cursor  = (joy_mode == JOY_CURSOR);

	// Sinclair I+II splits the two pads over both rows
	assign row_60 = ({5{joy_mode inside {JOY_SINCLAIR1, JOY_SINCLAIR12}}} & sinclair1_keys(joy0)) |
			({5{joy_mode == JOY_SINCLAIR1}} & sinclair1_keys(joy1)) |
			({5{cursor}} & {joy_any.down, joy_any.up, joy_any.right, 1'b0, joy_any.fire1});

	// Cursor left sits on key 5
	assign row_15 = ({5{joy_mode inside {JOY_SINCLAIR2, JOY_SINCLAIR12}}} & sinclair2_keys(joy1)) |
			({5{joy_mode == JOY_SINCLAIR2}} & sinclair2_keys(joy0)) |
			({5{cursor}} & {joy_any.left, 4'b0000});

	// Row is scanned when its address line is low
	assign joy_kbd = ({5{bus.addr[12]}} | ~row_60) & ({5{bus.addr[11]}} | ~row_15);

	always_ff @(posedge clk_sys) begin
		kbd_dout  <= key_data & joy_kbd;
		kemp_dout <= (joy_mode == JOY_KEMPSTON) ? {2'b00, joy_any} : 8'h00;
	end

endmodule

`default_nettype wire

// File: design/zx_ula_port.sv
// ==========================================================================
// ZX ULA port and read mux
// Port FE border and EAR/MIC latch, keyboard read and CPU input data
// ==========================================================================

`timescale 1ns/1ps
`default_nettype none

module zx_ula_port (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  zx_bus_pkg::cpu_bus_t bus,
	input  logic [4:0]           kbd_dout,
	input  logic [7:0]           kemp_dout,
	output logic [7:0]           cpu_din,
	output logic [2:0]           border_color,
	output logic                 ear,
	output logic                 mic
);

	import zx_bus_pkg::*;

	logic io_wr_d;
	logic ula_sel;
	logic kemp_sel;

	// ULA answers on any even port
	assign ula_sel  = !bus.addr[0];
	assign kemp_sel = (bus.addr[5:0] == PORT_KEMPSTON[5:0]);

	always_ff @(posedge clk_sys) begin
		io_wr_d <= bus.io_wr;

		if (reset) begin
			border_color <= 3'd0;
			ear          <= 1'b0;
			mic          <= 1'b0;
		end else if (bus.io_wr && !io_wr_d && ula_sel) begin
			border_color <= bus.dout[2:0];
			ear          <= bus.dout[4];
			mic          <= bus.dout[3];
		end
	end

	// ======================================================================
	// CPU read data
	// ======================================================================
	always_comb begin
		if (bus.io_rd && kemp_sel) begin
			cpu_din = kemp_dout;
		end else if (bus.io_rd && ula_sel) begin
			// Tape input loops back from the EAR and MIC outputs
			cpu_din = {1'b1, ear | mic, 1'b1, kbd_dout};
		end else begin
			cpu_din = IDLE_BYTE;
		end
	end

endmodule

`default_nettype wire

// File: design/zx_mem_core.sv
// ==========================================================================
// ZX memory and port core
// Paging, RAM mapping, joystick and ULA port blocks on one CPU bus
// ==========================================================================

`timescale 1ns/1ps
`default_nettype none

module zx_mem_core (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  zx_bus_pkg::cpu_bus_t   bus,
	input  zx_mem_pkg::mem_model_t mem_model,
	input  zx_bus_pkg::joy_mode_t  joy_mode,
	input  zx_bus_pkg::joy_t       joy0,
	input  zx_bus_pkg::joy_t       joy1,
	input  logic [4:0]             key_data,
	output zx_mem_pkg::ram_req_t   ram,
	output logic [7:0]             cpu_din,
	output logic [2:0]             border_color,
	output logic                   ear,
	output logic                   mic
);

	import zx_mem_pkg::*;

	page_state_t pages;
	logic [3:0]  rom_page;
	logic [4:0]  kbd_dout;
	logic [7:0]  kemp_dout;

	zx_paging u_paging (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.bus       (bus),
		.mem_model (mem_model),
		.pages     (pages),
		.rom_page  (rom_page)
	);

	zx_ram_map u_ram_map (
		.bus      (bus),
		.pages    (pages),
		.rom_page (rom_page),
		.ram      (ram)
	);

	zx_joystick u_joystick (
		.clk_sys   (clk_sys),
		.bus       (bus),
		.joy_mode  (joy_mode),
		.joy0      (joy0),
		.joy1      (joy1),
		.key_data  (key_data),
		.kbd_dout  (kbd_dout),
		.kemp_dout (kemp_dout)
	);

	zx_ula_port u_ula_port (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.bus          (bus),
		.kbd_dout     (kbd_dout),
		.kemp_dout    (kemp_dout),
		.cpu_din      (cpu_din),
		.border_color (border_color),
		.ear          (ear),
		.mic          (mic)
	);

endmodule

`default_nettype wire

// File: dv/tb_clock.sv
// ==========================================================================
// Testbench clock and reset
// 10 ns clock, reset held for 3 cycles at start and on each restart
// ==========================================================================

`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD_NS    = 10,
	parameter int RESET_CYCLES = 3
) (
	input  logic restart,
	output logic clk_sys,
	output logic reset
);

	int rst_cnt = RESET_CYCLES;

	initial begin
		clk_sys = 1'b0;
		forever #(PERIOD_NS / 2) clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		if (restart) begin
			rst_cnt <= RESET_CYCLES;
		end else if (rst_cnt > 0) begin
			rst_cnt <= rst_cnt - 1;
		end
	end

	assign reset = (rst_cnt > 0);

endmodule

`default_nettype wire

// File: dv/zx_mem_core_assertions.sv
// ==========================================================================
// ZX memory core checker
// Shadow paging registers and concurrent checks on RAM requests,
// port FE latch and CPU read data
// ==========================================================================

`timescale 1ns/1ps
`default_nettype none

module zx_mem_core_assertions (
	input logic                   clk_sys,
	input logic                   reset,
	input zx_bus_pkg::cpu_bus_t   bus,
	input zx_mem_pkg::mem_model_t mem_model,
	input zx_bus_pkg::joy_mode_t  joy_mode,
	input zx_bus_pkg::joy_t       joy0,
	input zx_bus_pkg::joy_t       joy1,
	input logic [4:0]             key_data,
	input zx_mem_pkg::ram_req_t   ram,
	input logic [7:0]             cpu_din,
	input logic [2:0]             border_color,
	input logic                   ear,
	input logic                   mic
);

	import zx_bus_pkg::*;
	import zx_mem_pkg::*;

	logic [7:0] sh_7ffd, sh_1ffd, sh_eff7;
	logic [2:0] sh_ext;
	// Port FE latch as border, EAR, MIC
	logic [4:0] sh_fe;
	logic       is_48, is_p1024, is_pf1024, is_plus3;
	logic       io_wr_q, rd_q, locked;
	logic [15:0] addr_q;
	joy_mode_t  mode_q;
	joy_t       joy_or_q;
	logic [4:0] key_q, kbd_exp;
	logic [3:0] exp_rom;
	logic [6:0] exp_bank;
	logic [RAM_ADDR_W-1:0] exp_addr;
	logic       exp_we;
	logic [7:0] kemp_exp, ula_exp;
	int addr_errs = 0;
	int we_errs = 0;
	int req_errs = 0;
	int ula_errs = 0;
	int rd_errs = 0;
	int err_count;

	// Fixed bank sets of the +3 all-RAM modes
	function automatic logic [2:0] plus3_bank(input logic [1:0] set, input logic [1:0] slot);
		case (set)
			2'd0:    return {1'b0, slot};
			2'd1:    return {1'b1, slot};
			2'd2:    return (slot == 2'd3) ? 3'd3 : {1'b1, slot};
			default: return (slot == 2'd0) ? 3'd4 : (slot == 2'd1) ? 3'd7 :
					(slot == 2'd2) ? 3'd6 : 3'd3;
		endcase
	endfunction

	assign locked = is_48 || (sh_7ffd[5] && (!is_p1024 || sh_eff7[2]));
	assign err_count = addr_errs + we_errs + req_errs + ula_errs + rd_errs;

	always_ff @(posedge clk_sys) begin
		io_wr_q  <= bus.io_wr;
		rd_q     <= bus.io_rd;
		addr_q   <= bus.addr;
		mode_q   <= joy_mode;
		joy_or_q <= joy0 | joy1;
		key_q    <= key_data;
		if (reset) begin
			sh_7ffd   <= 8'h00;
			sh_1ffd   <= 8'h00;
			sh_eff7   <= 8'h00;
			sh_ext    <= 3'd0;
			sh_fe     <= 5'd0;
			is_48     <= (mem_model == MEM_48K);
			is_p1024  <= (mem_model == MEM_P1024);
			is_pf1024 <= (mem_model == MEM_PF1024);
			is_plus3  <= (mem_model == MEM_PLUS3);
		end else if (bus.io_wr && !io_wr_q) begin
			if (bus.addr == PORT_7FFD && !locked) begin
				sh_7ffd <= bus.dout;
				if (is_p1024 && !sh_eff7[2])
					sh_ext <= {bus.dout[5], bus.dout[7:6]};
			end
			if (bus.addr == PORT_1FFD && is_plus3 && !locked)
				sh_1ffd <= bus.dout;
			if (bus.addr == PORT_EFF7 && is_p1024)
				sh_eff7 <= bus.dout;
			if (bus.addr == PORT_DFFD && is_pf1024)
				sh_ext <= bus.dout[2:0];
			if (!bus.addr[0])
				sh_fe <= {bus.dout[2:0], bus.dout[4], bus.dout[3]};
		end
	end

	// ======================================================================
	// Expected values
	// ======================================================================
	always_comb begin
		if (is_plus3)
			exp_rom = {2'b10, sh_1ffd[2], sh_7ffd[4]};
		else
			exp_rom = is_48 ? 4'b1111 : {3'b011, sh_7ffd[4]};
		if (sh_1ffd[0])
			exp_bank = {4'b0000, plus3_bank(sh_1ffd[2:1], bus.addr[15:14])};
		else if (bus.addr[15:14] == 2'd0)
			exp_bank = {3'b101, exp_rom};
		else if (bus.addr[15:14] == 2'd1)
			exp_bank = 7'd5;
		else if (bus.addr[15:14] == 2'd2)
			exp_bank = 7'd2;
		else
			exp_bank = {1'b0, sh_ext, sh_7ffd[2:0]};
		exp_addr = {4'b0000, exp_bank, bus.addr[13:0]};
		exp_we   = bus.mem_wr && (sh_1ffd[0] || bus.addr[15:14] != 2'd0);
		// Sinclair I keys 6..0 read with address bit 12 low
		if (mode_q == JOY_SINCLAIR1 && !addr_q[12])
			kbd_exp = key_q & ~{joy_or_q.left, joy_or_q.right, joy_or_q.down,
					joy_or_q.up, joy_or_q.fire1};
		else
			kbd_exp = key_q;
		kemp_exp = (mode_q == JOY_KEMPSTON) ? {2'b00, joy_or_q} : 8'h00;
		ula_exp  = {1'b1, sh_fe[1] | sh_fe[0], 1'b1, kbd_exp};
	end

	a_ram_addr: assert property (@(posedge clk_sys) disable iff (reset)
			(bus.mem_rd || bus.mem_wr) |-> ram.addr == exp_addr)
		else begin
			addr_errs++;
			$error("Error at %0t: ram.addr got %h expected %h", $time,
				$sampled(ram.addr), $sampled(exp_addr));
		end

	a_ram_we: assert property (@(posedge clk_sys) disable iff (reset) ram.we == exp_we)
		else begin
			we_errs++;
			$error("Error at %0t: ram.we got %b expected %b", $time,
				$sampled(ram.we), $sampled(exp_we));
		end

	a_ram_req: assert property (@(posedge clk_sys) disable iff (reset)
			ram.rd == bus.mem_rd && (!bus.mem_wr || ram.din == bus.dout))
		else begin
			req_errs++;
			$error("Error at %0t: ram.rd/ram.din got %b/%h expected %b/%h", $time,
				$sampled(ram.rd), $sampled(ram.din), $sampled(bus.mem_rd),
				$sampled(bus.dout));
		end

	a_ula_latch: assert property (@(posedge clk_sys) disable iff (reset)
			{border_color, ear, mic} == sh_fe)
		else begin
			ula_errs++;
			$error("Error at %0t: border/ear/mic got %b expected %b", $time,
				$sampled({border_color, ear, mic}), $sampled(sh_fe));
		end

	a_idle_read: assert property (@(posedge clk_sys) disable iff (reset)
			!bus.io_rd |-> cpu_din == IDLE_BYTE)
		else begin
			rd_errs++;
			$error("Error at %0t: cpu_din got %h expected %h", $time,
				$sampled(cpu_din), IDLE_BYTE);
		end

	a_kempston: assert property (@(posedge clk_sys) disable iff (reset)
			(bus.io_rd && rd_q && bus.addr == addr_q && bus.addr[7:0] == PORT_KEMPSTON)
			|-> cpu_din == kemp_exp)
		else begin
			rd_errs++;
			$error("Error at %0t: cpu_din got %h expected %h", $time,
				$sampled(cpu_din), $sampled(kemp_exp));
		end

	a_ula_read: assert property (@(posedge clk_sys) disable iff (reset)
			(bus.io_rd && rd_q && bus.addr == addr_q && !bus.addr[0] &&
			(mode_q == JOY_KEMPSTON || mode_q == JOY_SINCLAIR1)) |-> cpu_din == ula_exp)
		else begin
			rd_errs++;
			$error("Error at %0t: cpu_din got %h expected %h", $time,
				$sampled(cpu_din), $sampled(ula_exp));
		end

endmodule

bind zx_mem_core zx_mem_core_assertions u_checker (
	.clk_sys(clk_sys), .reset(reset), .bus(bus), .mem_model(mem_model),
	.joy_mode(joy_mode), .joy0(joy0), .joy1(joy1), .key_data(key_data),
	.ram(ram), .cpu_din(cpu_din), .border_color(border_color), .ear(ear), .mic(mic)
);

`default_nettype wire

// File: dv/zx_mem_core_tb.sv
// ==========================================================================
// ZX memory core testbench
// Drives paging, port FE and joystick traffic; bound checker judges it
// ==========================================================================

`timescale 1ns/1ps
`default_nettype none

module zx_mem_core_tb;

	import zx_bus_pkg::*;
	import zx_mem_pkg::*;

	localparam int TEST_CYCLES = 400;
	localparam int CLK_NS      = 10;

	logic       clk_sys, reset, restart;
	cpu_bus_t   bus;
	mem_model_t mem_model;
	joy_mode_t  joy_mode;
	joy_t       joy0, joy1;
	logic [4:0] key_data;
	ram_req_t   ram;
	logic [7:0] cpu_din;
	logic [2:0] border_color;
	logic       ear, mic;
	int seed = 31191;
	int rnd;
	int passed = 0;
	int failed = 0;
	int errs_seen = 0;

	tb_clock u_clock (.restart(restart), .clk_sys(clk_sys), .reset(reset));

	zx_mem_core dut (.*);

	task automatic restart_as(input mem_model_t model);
		@(posedge clk_sys);
		mem_model <= model;
		restart   <= 1'b1;
		@(posedge clk_sys);
		restart <= 1'b0;
		@(posedge clk_sys);
		while (reset) @(posedge clk_sys);
	endtask

	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		@(posedge clk_sys);
		bus.addr  <= addr;
		bus.dout  <= data;
		bus.io_wr <= 1'b1;
		@(posedge clk_sys);
		bus.io_wr <= 1'b0;
		@(posedge clk_sys);
	endtask

	// Held two cycles so the registered read sources settle
	task automatic io_read(input logic [15:0] addr);
		@(posedge clk_sys);
		bus.addr  <= addr;
		bus.io_rd <= 1'b1;
		repeat (2) @(posedge clk_sys);
		bus.io_rd <= 1'b0;
	endtask

	task automatic mem_cycle(input logic [15:0] addr, input logic [7:0] data, input logic wr);
		@(posedge clk_sys);
		bus.addr   <= addr;
		bus.dout   <= data;
		bus.mem_rd <= !wr;
		bus.mem_wr <= wr;
		@(posedge clk_sys);
		bus.mem_rd <= 1'b0;
		bus.mem_wr <= 1'b0;
	endtask

	task automatic end_test(input string name);
		int errs;
		repeat (2) @(posedge clk_sys);
		// Counts are read between clock edges
		@(negedge clk_sys);
		errs = dut.u_checker.err_count;
		if (errs == errs_seen) begin
			passed++;
			$display("Test %s: pass", name);
		end else begin
			failed++;
			$display("Test %s: FAIL, %0d check(s) failed", name, errs - errs_seen);
		end
		errs_seen = errs;
	endtask

	initial begin
		#(20 * TEST_CYCLES * CLK_NS);
		$display("Watchdog: run did not finish within %0d ns", 20 * TEST_CYCLES * CLK_NS);
		$display("Something failed");
		$finish;
	end

	initial begin
		restart   = 1'b0;
		bus       = '0;
		mem_model = MEM_128K;
		joy_mode  = JOY_KEMPSTON;
		joy0      = '0;
		joy1      = '0;
		key_data  = 5'h1F;
		restart_as(MEM_128K);

		repeat (4) begin
			rnd = $random(seed);
			io_write(PORT_7FFD, {3'b000, rnd[4], 1'b0, rnd[2:0]});
			mem_cycle({2'b11, rnd[21:8]}, 8'h00, 1'b0);
			mem_cycle({2'b00, rnd[29:16]}, 8'h00, 1'b0);
		end
		end_test("128k_banks");

		io_write(PORT_7FFD, 8'h23);
		io_write(PORT_7FFD, 8'h06);
		mem_cycle(16'hC010, 8'h00, 1'b0);
		restart_as(MEM_128K);
		mem_cycle(16'hC010, 8'h00, 1'b0);
		end_test("7ffd_lock");

		restart_as(MEM_PLUS3);
		mem_cycle(16'h0040, 8'h5A, 1'b1);
		for (int s = 0; s < 4; s++) begin
			io_write(PORT_1FFD, {5'b00000, s[1:0], 1'b1});
			for (int t = 0; t < 4; t++) begin
				mem_cycle({t[1:0], 14'h0155}, 8'hA5, 1'b1);
			end
		end
		io_write(PORT_1FFD, 8'h04);
		mem_cycle(16'h0155, 8'hA5, 1'b1);
		mem_cycle(16'h0155, 8'h00, 1'b0);
		end_test("plus3_special");

		restart_as(MEM_P1024);
		repeat (4) begin
			rnd = $random(seed);
			io_write(PORT_7FFD, rnd[7:0]);
			mem_cycle({2'b11, rnd[21:8]}, 8'h00, 1'b0);
		end
		restart_as(MEM_PF1024);
		repeat (4) begin
			rnd = $random(seed);
			io_write(PORT_DFFD, {5'b00000, rnd[2:0]});
			io_write(PORT_7FFD, {5'b00000, rnd[6:4]});
			mem_cycle({2'b11, rnd[21:8]}, 8'h00, 1'b0);
		end
		end_test("extended_banks");

		restart_as(MEM_128K);
		repeat (4) begin
			rnd = $random(seed);
			@(posedge clk_sys);
			key_data <= rnd[12:8];
			io_write(16'h00FE, rnd[7:0]);
			io_read(16'h00FE);
		end
		end_test("port_fe");

		repeat (4) begin
			rnd = $random(seed);
			@(posedge clk_sys);
			joy0     <= rnd[5:0];
			joy1     <= rnd[13:8];
			key_data <= rnd[20:16];
			joy_mode <= JOY_KEMPSTON;
			io_read(16'h001F);
			@(posedge clk_sys);
			joy_mode <= JOY_SINCLAIR1;
			io_read(16'hEFFE);
			io_read(16'hF7FE);
		end
		end_test("joystick");

		$display("Tests passed: %0d, failed: %0d", passed, failed);
		if (failed == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
design/zx_bus_pkg.sv
design/zx_mem_pkg.sv
design/zx_paging.sv
design/zx_ram_map.sv
design/zx_joystick.sv
design/zx_ula_port.sv
design/zx_mem_core.sv
dv/tb_clock.sv
dv/zx_mem_core_assertions.sv
dv/zx_mem_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the zx_mem_core testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert --top-module zx_mem_core_tb \
	-f verilog.f -o zx_sim; then
	echo "Verilator build failed"
	exit 1
fi

if ! ./obj_dir/zx_sim +verilator+error+limit+1000 > "$LOG" 2>&1; then
	cat "$LOG"
	echo "Simulation exited with an error"
	exit 1
fi

cat "$LOG"

if grep -q "Something failed" "$LOG"; then
	exit 1
fi
if ! grep -q "Everything OK" "$LOG"; then
	echo "Simulation ended without a result"
	exit 1
fi
exit 0
